/* tb.f */
logic/core_pkg.sv
logic/pipe_ifu.sv
logic/pipe_idu.sv
logic/pipe_mprf.sv
logic/pipe_csr.sv
logic/pipe_exu.sv
logic/pipe_top.sv
tb/pipe_top_asserts.sv
tb/tb_pipe_top.sv

/* tb/tb_pipe_top.sv */
/*
 * Pipeline testbench: clock, reset, random instruction memory with random
 * ack delay, instruction-level reference model and result checks
 */

`timescale 1ns/1ps

module tb_pipe_top;

localparam logic [31:0] RESET_PC   = 32'h0000_0000;
localparam logic [31:0] MTVEC_INIT = 32'h0000_0080;
localparam int NUM_RETIRE = 2000;
localparam int TIMEOUT    = 12000;     // 4 cycles per instruction plus margin

logic        clk = 1'b0;
logic        i_rst, i_imem_ack;
logic [31:0] i_imem_rdata, i_fuse_mhartid;
logic        o_imem_req, o_wb_valid, o_trap;
logic [31:0] o_imem_addr, o_wb_data, o_trap_cause;
logic [4:0]  o_wb_addr;

logic [31:0] imem [0:255];
logic [31:0] rng = 32'd13;
logic [31:0] fetch_q [$];              // Acked addresses, oldest first
logic [31:0] m_regs [0:31];
logic [31:0] m_pc, m_mscratch, m_mepc, m_mcause, m_mtvec;
int          cycles, retired, err_value, err_other, wait_cnt;
bit          seen_req, seen_ack;

pipe_top #(.RESET_PC(RESET_PC), .MTVEC_INIT(MTVEC_INIT)) uut (.*);

always #2 clk = ~clk;

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
endfunction

function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [11:0] csrs [0:5];
    logic [4:0]  rs1;
    csrs = '{12'h305, 12'h340, 12'h341, 12'h342, 12'hF14, 12'h7C0};   // Last one unknown
    r = next_rand();
    rs1 = (r[9:8] == 2'b00) ? 5'd0 : r[14:10];
    case (r[3:0])
        4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5:
            return {(r[4:0] == 5'd5) ? 7'h20 : 7'h00, r[19:15], rs1,
                    r[31:29], r[24:20], 7'h33};
        4'd6, 4'd7, 4'd15: return {r[31:20], rs1, 3'b000, r[24:20], 7'h13};
        4'd8, 4'd9, 4'd10, 4'd11:
            return {csrs[r[31:28] % 6], rs1, r[5] ? 3'b010 : 3'b001, r[24:20], 7'h73};
        4'd12: return 32'h0000_0073;                     // ECALL
        4'd13: return 32'h3020_0073;                     // MRET
        default: return {25'(next_rand() >> 7), 7'h7F};  // Illegal opcode
    endcase
endfunction

// One instruction of the model; kind 0 none, 1 write-back, 2 trap
task automatic exec_one(output int kind, output logic [4:0] rd, output logic [31:0] val,
                        output logic [31:0] cause, output logic [31:0] tgt);
    logic [31:0] w, a, b, old, nxt;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] csr;
    logic        wb, trap, known, wr;
    w = imem[m_pc[9:2]];
    f3 = w[14:12];
    f7 = w[31:25];
    csr = w[31:20];
    rd = w[11:7];
    a = m_regs[w[19:15]];
    b = m_regs[w[24:20]];
    wb = 1'b1;
    trap = 1'b0;
    val = '0;
    old = '0;
    cause = 32'd2;
    tgt = m_mtvec;
    nxt = m_pc + 32'd4;
    if (w[6:0] == 7'h33 && f7 == 7'h00 && f3 == 3'b000) val = a + b;
    else if (w[6:0] == 7'h33 && f7 == 7'h20 && f3 == 3'b000) val = a - b;
    else if (w[6:0] == 7'h33 && f7 == 7'h00 && f3 == 3'b100) val = a ^ b;
    else if (w[6:0] == 7'h33 && f7 == 7'h00 && f3 == 3'b110) val = a | b;
    else if (w[6:0] == 7'h33 && f7 == 7'h00 && f3 == 3'b111) val = a & b;
    else if (w[6:0] == 7'h13 && f3 == 3'b000) val = a + {{20{w[31]}}, w[31:20]};
    else if (w == 32'h0000_0073) begin
        trap = 1'b1;
        cause = 32'd11;
    end else if (w == 32'h3020_0073) begin
        wb = 1'b0;
        nxt = m_mepc;
    end else if (w[6:0] == 7'h73 && (f3 == 3'b001 || f3 == 3'b010)) begin
        known = 1'b1;
        case (csr)
            12'h305: old = m_mtvec;
            12'h340: old = m_mscratch;
            12'h341: old = m_mepc;
            12'h342: old = m_mcause;
            12'hF14: old = i_fuse_mhartid;
            default: known = 1'b0;
        endcase
        wr = (f3 == 3'b001) || (w[19:15] != 5'd0);
        trap = !known || (wr && csr == 12'hF14);
        val = old;
        b = (f3 == 3'b001) ? a : (old | a);
        if (!trap && wr) begin
            case (csr)
                12'h305: m_mtvec = b & ~32'd3;
                12'h340: m_mscratch = b;
                12'h341: m_mepc = b & ~32'd3;
                12'h342: m_mcause = b;
                default: ;
            endcase
        end
    end else begin
        trap = 1'b1;
    end
    if (trap) begin
        kind = 2;
        m_mepc = m_pc;
        m_mcause = cause;
        nxt = m_mtvec;
    end else if (wb && rd != 5'd0) begin
        kind = 1;
        m_regs[rd] = val;
    end else begin
        kind = 0;
    end
    m_pc = nxt;
endtask

// Runs the model through silent instructions up to the one that strobes
task automatic check_retire();
    int          kind, steps;
    logic [4:0]  rd;
    logic [31:0] val, cause, tgt, addr;
    kind = 0;
    steps = 0;
    while (kind == 0 && steps < 300) begin
        if (fetch_q.size() == 0) begin
            err_other++;
            $display("Retirement seen with no fetched instruction left to execute");
            return;
        end
        addr = fetch_q.pop_front();
        assert (addr == m_pc) else begin
            err_value++;
            $display("ERROR o_imem_addr: got %h, expected %h", addr, m_pc);
        end
        exec_one(kind, rd, val, cause, tgt);
        steps++;
    end
    if (kind == 1) begin
        assert (o_wb_valid && o_wb_addr == rd && o_wb_data == val) else begin
            err_value++;
            $display("ERROR o_wb_addr/o_wb_data: got %h/%h, expected %h/%h",
                     o_wb_addr, o_wb_data, rd, val);
        end
    end else if (kind == 2) begin
        assert (o_trap && o_trap_cause == cause && o_imem_addr == tgt) else begin
            err_value++;
            $display("ERROR o_trap_cause/o_imem_addr: got %h/%h, expected %h/%h",
                     o_trap_cause, o_imem_addr, cause, tgt);
        end
    end else begin
        err_other++;
        $display("Model ran 300 instructions without a strobe");
    end
endtask

task automatic report_and_finish();
    int err_assert;
    err_assert = uut.u_pipe_top_asserts.fail_cnt;
    $display("Retired %0d, value errors %0d, other errors %0d, assertion errors %0d",
             retired, err_value, err_other, err_assert);
    if (err_value == 0 && err_other == 0 && err_assert == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
endtask

initial begin
    i_rst = 1'b1;
    i_imem_ack = 1'b0;
    i_imem_rdata = '0;
    i_fuse_mhartid = next_rand();
    imem[0] = {12'h305, 5'd0, 3'b001, 5'd0, 7'h73};       // mtvec = 0
    for (int i = 1; i < 32; i++) begin
        imem[i] = {12'(next_rand() >> 20), 5'd0, 3'b000, 5'(i), 7'h13};
    end
    imem[32] = {12'h100, 5'd0, 3'b000, 5'd1, 7'h13};
    imem[33] = {12'h305, 5'd1, 3'b001, 5'd0, 7'h73};      // mtvec = 0x100
    for (int i = 34; i < 256; i++) imem[i] = random_instr();
    m_regs = '{default: '0};
    {m_mscratch, m_mepc, m_mcause} = '0;
    m_mtvec = MTVEC_INIT;
    m_pc = RESET_PC;
    wait_cnt = next_rand() % 4;
    repeat (16) @(posedge clk);
    @(negedge clk) i_rst <= 1'b0;
end

// ------------------------------
// Checks and memory, falling edge
// ------------------------------
always @(negedge clk) begin
    if (!i_rst) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout after %0d cycles with %0d retirements", cycles, retired);
            $display("TESTBENCH FAILED");
            $finish;
        end else if (retired >= NUM_RETIRE) begin
            report_and_finish();
        end else begin
            if (!seen_ack) begin
                assert (!o_wb_valid && !o_trap) else begin
                    err_other++;
                    $display("Retire strobe before the first fetch was acked");
                end
            end
            if (o_imem_req && !seen_req) begin
                seen_req = 1'b1;
                assert (o_imem_addr == RESET_PC) else begin
                    err_value++;
                    $display("ERROR o_imem_addr: got %h, expected %h", o_imem_addr, RESET_PC);
                end
            end
            if (o_wb_valid || o_trap) begin
                retired++;
                check_retire();
            end
            i_imem_ack = 1'b0;
            if (o_imem_req) begin
                if (wait_cnt == 0) begin
                    i_imem_ack = 1'b1;          // Word for the address seen now
                    i_imem_rdata = imem[o_imem_addr[9:2]];
                    fetch_q.push_back(o_imem_addr);
                    seen_ack = 1'b1;
                    wait_cnt = next_rand() % 4;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end
end

endmodule : tb_pipe_top

/* tb/pipe_top_asserts.sv */
/*
 * Concurrent assertions on the fetch request, fetch address and retire strobes,
 * bound into the pipeline top
 */

`timescale 1ns/1ps

module pipe_top_asserts import core_pkg::*; (
    input logic            clk,
    input logic            i_rst,
    input logic            o_imem_req,
    input logic [XLEN-1:0] o_imem_addr,
    input logic            o_wb_valid,
    input logic            o_trap
);

int fail_cnt;   // Failed assertions so far

// No fetch while reset holds
req_low_in_reset: assert property (@(posedge clk) i_rst && $past(i_rst) |-> !o_imem_req)
    else begin
        $error("o_imem_req high during reset");
        fail_cnt++;
    end

// Write-back and trap exclude each other
wb_trap_exclusive: assert property (@(posedge clk) disable iff (i_rst) !(o_wb_valid && o_trap))
    else begin
        $error("o_wb_valid and o_trap high together");
        fail_cnt++;
    end

addr_aligned: assert property (@(posedge clk) disable iff (i_rst) o_imem_addr[1:0] == 2'b00)
    else begin
        $error("o_imem_addr not word aligned");
        fail_cnt++;
    end

endmodule : pipe_top_asserts

bind pipe_top pipe_top_asserts u_pipe_top_asserts (
    .clk         (clk        ),
    .i_rst       (i_rst      ),
    .o_imem_req  (o_imem_req ),
    .o_imem_addr (o_imem_addr),
    .o_wb_valid  (o_wb_valid ),
    .o_trap      (o_trap     )
);

/* logic/pipe_top.sv */
/*
 * Pipeline top: fetch, decode, register file, CSR and execution units
 */

`timescale 1ns/1ps

module pipe_top import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC   = 32'h0000_0000,
    parameter logic [XLEN-1:0] MTVEC_INIT = 32'h0000_0080
) (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_imem_ack,
    input  logic [XLEN-1:0]       i_imem_rdata,
    input  logic [XLEN-1:0]       i_fuse_mhartid,
    output logic                  o_imem_req,
    output logic [XLEN-1:0]       o_imem_addr,
    output logic                  o_wb_valid,
    output logic [REG_ADDR_W-1:0] o_wb_addr,
    output logic [XLEN-1:0]       o_wb_data,
    output logic                  o_trap,
    output logic [XLEN-1:0]       o_trap_cause
);

// IFU to IDU/EXU
logic [XLEN-1:0]       ifu2idu_instr;
logic [XLEN-1:0]       ifu2exu_pc;
logic                  instr_vd;
logic                  new_pc_req;     // Trap or MRET redirect
logic [XLEN-1:0]       new_pc;

// IDU to EXU
alu_op_e               idu2exu_op;
logic [REG_ADDR_W-1:0] idu2exu_rs1_addr;
logic [REG_ADDR_W-1:0] idu2exu_rs2_addr;
logic [REG_ADDR_W-1:0] idu2exu_rd_addr;
logic [XLEN-1:0]       idu2exu_imm;
logic                  idu2exu_use_imm;
logic [CSR_ADDR_W-1:0] idu2exu_csr_addr;

// EXU and MPRF
logic [REG_ADDR_W-1:0] exu2mprf_rs1_addr;
logic [REG_ADDR_W-1:0] exu2mprf_rs2_addr;
logic [XLEN-1:0]       mprf2exu_rs1_data;
logic [XLEN-1:0]       mprf2exu_rs2_data;
logic                  exu2mprf_w_req;
logic [REG_ADDR_W-1:0] exu2mprf_rd_addr;
logic [XLEN-1:0]       exu2mprf_rd_data;

// EXU and CSR
logic                  exu2csr_r_req;
logic                  exu2csr_w_req;
alu_op_e               exu2csr_w_cmd;
csr_addr_e             exu2csr_addr;
logic [XLEN-1:0]       exu2csr_w_data;
logic                  exu2csr_take_exc;
logic [XLEN-1:0]       exu2csr_exc_cause;
logic [XLEN-1:0]       exu2csr_exc_pc;
logic                  exu2csr_mret;
logic [XLEN-1:0]       csr2exu_r_data;
logic                  csr2exu_rw_exc;
logic [XLEN-1:0]       csr2exu_new_pc;

// ------------------------------
// Fetch and decode
// ------------------------------
pipe_ifu #(
    .RESET_PC       (RESET_PC        )
) i_pipe_ifu (
    .clk            (clk             ),
    .i_rst          (i_rst           ),
    .i_imem_ack     (i_imem_ack      ),
    .i_imem_rdata   (i_imem_rdata    ),
    .i_new_pc_req   (new_pc_req      ),
    .i_new_pc       (new_pc          ),
    .o_imem_req     (o_imem_req      ),
    .o_imem_addr    (o_imem_addr     ),
    .o_instr        (ifu2idu_instr   ),
    .o_instr_pc     (ifu2exu_pc      ),
    .o_instr_vd     (instr_vd        )
);

pipe_idu i_pipe_idu (
    .i_instr        (ifu2idu_instr   ),
    .o_op           (idu2exu_op      ),
    .o_rs1_addr     (idu2exu_rs1_addr),
    .o_rs2_addr     (idu2exu_rs2_addr),
    .o_rd_addr      (idu2exu_rd_addr ),
    .o_imm          (idu2exu_imm     ),
    .o_use_imm      (idu2exu_use_imm ),
    .o_csr_addr     (idu2exu_csr_addr)
);

// ------------------------------
// Register file and CSRs
// ------------------------------
pipe_mprf i_pipe_mprf (
    .clk            (clk              ),
    .i_rs1_addr     (exu2mprf_rs1_addr),
    .i_rs2_addr     (exu2mprf_rs2_addr),
    .i_w_req        (exu2mprf_w_req   ),
    .i_rd_addr      (exu2mprf_rd_addr ),
    .i_rd_data      (exu2mprf_rd_data ),
    .o_rs1_data     (mprf2exu_rs1_data),
    .o_rs2_data     (mprf2exu_rs2_data)
);

pipe_csr #(
    .MTVEC_INIT     (MTVEC_INIT       )
) i_pipe_csr (
    .clk            (clk              ),
    .i_rst          (i_rst            ),
    .i_r_req        (exu2csr_r_req    ),
    .i_w_req        (exu2csr_w_req    ),
    .i_w_cmd        (exu2csr_w_cmd    ),
    .i_addr         (exu2csr_addr     ),
    .i_w_data       (exu2csr_w_data   ),
    .i_take_exc     (exu2csr_take_exc ),
    .i_exc_cause    (exu2csr_exc_cause),
    .i_exc_pc       (exu2csr_exc_pc   ),
    .i_mret         (exu2csr_mret     ),
    .i_fuse_mhartid (i_fuse_mhartid   ),
    .o_r_data       (csr2exu_r_data   ),
    .o_rw_exc       (csr2exu_rw_exc   ),
    .o_new_pc       (csr2exu_new_pc   )
);

// ------------------------------
// Execution
// ------------------------------
pipe_exu i_pipe_exu (
    .i_instr_vd      (instr_vd         ),
    .i_instr_pc      (ifu2exu_pc       ),
    .i_op            (idu2exu_op       ),
    .i_rs1_addr      (idu2exu_rs1_addr ),
    .i_rs2_addr      (idu2exu_rs2_addr ),
    .i_rd_addr       (idu2exu_rd_addr  ),
    .i_imm           (idu2exu_imm      ),
    .i_use_imm       (idu2exu_use_imm  ),
    .i_csr_addr      (idu2exu_csr_addr ),
    .i_rs1_data      (mprf2exu_rs1_data),
    .i_rs2_data      (mprf2exu_rs2_data),
    .i_csr_r_data    (csr2exu_r_data   ),
    .i_csr_rw_exc    (csr2exu_rw_exc   ),
    .i_csr_new_pc    (csr2exu_new_pc   ),
    .o_rs1_addr      (exu2mprf_rs1_addr),
    .o_rs2_addr      (exu2mprf_rs2_addr),
    .o_mprf_w_req    (exu2mprf_w_req   ),
    .o_mprf_rd_addr  (exu2mprf_rd_addr ),
    .o_mprf_rd_data  (exu2mprf_rd_data ),
    .o_csr_r_req     (exu2csr_r_req    ),
    .o_csr_w_req     (exu2csr_w_req    ),
    .o_csr_w_cmd     (exu2csr_w_cmd    ),
    .o_csr_addr      (exu2csr_addr     ),
    .o_csr_w_data    (exu2csr_w_data   ),
    .o_csr_take_exc  (exu2csr_take_exc ),
    .o_csr_exc_cause (exu2csr_exc_cause),
    .o_csr_exc_pc    (exu2csr_exc_pc   ),
    .o_csr_mret      (exu2csr_mret     ),
    .o_new_pc_req    (new_pc_req       ),
    .o_new_pc        (new_pc           ),
    .o_wb_valid      (o_wb_valid       ),
    .o_wb_addr       (o_wb_addr        ),
    .o_wb_data       (o_wb_data        ),
    .o_trap          (o_trap           ),
    .o_trap_cause    (o_trap_cause     )
);

endmodule : pipe_top

/* logic/pipe_exu.sv */
/*
 * Execution unit: operand select, integer ALU, CSR access control,
 * write-back, trap and redirect decisions
 */

`timescale 1ns/1ps

module pipe_exu import core_pkg::*; (
    input  logic                  i_instr_vd,
    input  logic [XLEN-1:0]       i_instr_pc,
    input  alu_op_e               i_op,
    input  logic [REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [REG_ADDR_W-1:0] i_rs2_addr,
    input  logic [REG_ADDR_W-1:0] i_rd_addr,
    input  logic [XLEN-1:0]       i_imm,
    input  logic                  i_use_imm,
    input  logic [CSR_ADDR_W-1:0] i_csr_addr,
    input  logic [XLEN-1:0]       i_rs1_data,
    input  logic [XLEN-1:0]       i_rs2_data,
    input  logic [XLEN-1:0]       i_csr_r_data,
    input  logic                  i_csr_rw_exc,
    input  logic [XLEN-1:0]       i_csr_new_pc,
    output logic [REG_ADDR_W-1:0] o_rs1_addr,
    output logic [REG_ADDR_W-1:0] o_rs2_addr,
    output logic                  o_mprf_w_req,
    output logic [REG_ADDR_W-1:0] o_mprf_rd_addr,
    output logic [XLEN-1:0]       o_mprf_rd_data,
    output logic                  o_csr_r_req,
    output logic                  o_csr_w_req,
    output alu_op_e               o_csr_w_cmd,
    output csr_addr_e             o_csr_addr,
    output logic [XLEN-1:0]       o_csr_w_data,
    output logic                  o_csr_take_exc,
    output logic [XLEN-1:0]       o_csr_exc_cause,
    output logic [XLEN-1:0]       o_csr_exc_pc,
    output logic                  o_csr_mret,
    output logic                  o_new_pc_req,
    output logic [XLEN-1:0]       o_new_pc,
    output logic                  o_wb_valid,
    output logic [REG_ADDR_W-1:0] o_wb_addr,
    output logic [XLEN-1:0]       o_wb_data,
    output logic                  o_trap,
    output logic [XLEN-1:0]       o_trap_cause
);

logic            is_alu;
logic            is_csr;
logic            exc;           // Instruction raises an exception
logic [XLEN-1:0] op_b;
logic [XLEN-1:0] alu_res;

assign is_alu = i_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
assign is_csr = (i_op == OP_CSRRW) | (i_op == OP_CSRRS);

assign o_rs1_addr = i_rs1_addr;
assign o_rs2_addr = i_rs2_addr;

// ------------------------------
// Integer ALU
// ------------------------------
assign op_b = i_use_imm ? i_imm : i_rs2_data;

always_comb begin
    case (i_op)
        OP_ADD:  alu_res = i_rs1_data + op_b;
        OP_SUB:  alu_res = i_rs1_data - op_b;
        OP_AND:  alu_res = i_rs1_data & op_b;
        OP_OR:   alu_res = i_rs1_data | op_b;
        OP_XOR:  alu_res = i_rs1_data ^ op_b;
        default: alu_res = '0;
    endcase
end

// ------------------------------
// CSR access
// ------------------------------
assign o_csr_r_req  = i_instr_vd & is_csr;
assign o_csr_w_req  = i_instr_vd & ((i_op == OP_CSRRW)
                    | ((i_op == OP_CSRRS) & (i_rs1_addr != '0)));  // CSRRS x0 only reads
assign o_csr_w_cmd  = i_op;
assign o_csr_addr   = csr_addr_e'(i_csr_addr);
assign o_csr_w_data = i_rs1_data;

// Traps and redirects
assign exc          = (i_op == OP_ECALL) | (i_op == OP_ILLEGAL) | (is_csr & i_csr_rw_exc);
assign o_trap       = i_instr_vd & exc;
assign o_trap_cause = (i_op == OP_ECALL) ? CAUSE_ECALL_M : CAUSE_ILLEGAL;

assign o_csr_take_exc  = o_trap;
assign o_csr_exc_cause = o_trap_cause;
assign o_csr_exc_pc    = i_instr_pc;
assign o_csr_mret      = i_instr_vd & (i_op == OP_MRET);

assign o_new_pc_req = o_trap | o_csr_mret;
assign o_new_pc     = i_csr_new_pc;          // mtvec or mepc from the CSR unit

// Write-back, nothing for x0
assign o_wb_valid = i_instr_vd & ~exc & (is_alu | is_csr) & (i_rd_addr != '0);
assign o_wb_addr  = i_rd_addr;
assign o_wb_data  = is_csr ? i_csr_r_data : alu_res;   // CSR ops return the old value

assign o_mprf_w_req   = o_wb_valid;
assign o_mprf_rd_addr = i_rd_addr;
assign o_mprf_rd_data = o_wb_data;

endmodule : pipe_exu

/* logic/pipe_csr.sv */
/*
 * Machine CSRs: mscratch, mepc, mcause, mtvec and the mhartid fuse,
 * CSR read/write access, trap entry and the MRET return target
 */

`timescale 1ns/1ps

module pipe_csr import core_pkg::*; #(
    parameter logic [XLEN-1:0] MTVEC_INIT = '0
) (
    input  logic            clk,
    input  logic            i_rst,
    input  logic            i_r_req,
    input  logic            i_w_req,
    input  alu_op_e         i_w_cmd,
    input  csr_addr_e       i_addr,
    input  logic [XLEN-1:0] i_w_data,
    input  logic            i_take_exc,
    input  logic [XLEN-1:0] i_exc_cause,
    input  logic [XLEN-1:0] i_exc_pc,
    input  logic            i_mret,
    input  logic [XLEN-1:0] i_fuse_mhartid,
    output logic [XLEN-1:0] o_r_data,
    output logic            o_rw_exc,
    output logic [XLEN-1:0] o_new_pc
);

logic [XLEN-1:0] csr_mscratch;
logic [XLEN-1:0] csr_mepc;
logic [XLEN-1:0] csr_mcause;
logic [XLEN-1:0] csr_mtvec;
logic            addr_hit;      // Address names an implemented CSR
logic            w_en;
logic [XLEN-1:0] w_value;

// ------------------------------
// Read mux
// ------------------------------
always_comb begin
    addr_hit = 1'b1;
    case (i_addr)
        CSR_MSCRATCH: o_r_data = csr_mscratch;
        CSR_MEPC:     o_r_data = csr_mepc;
        CSR_MCAUSE:   o_r_data = csr_mcause;
        CSR_MTVEC:    o_r_data = csr_mtvec;
        CSR_MHARTID:  o_r_data = i_fuse_mhartid;
        default: begin
            o_r_data = '0;
            addr_hit = 1'b0;
        end
    endcase
end

// Unknown address, or mhartid written
assign o_rw_exc = ((i_r_req | i_w_req) & ~addr_hit)
                | (i_w_req & (i_addr == CSR_MHARTID));

assign w_en    = i_w_req & ~o_rw_exc;
assign w_value = (i_w_cmd == OP_CSRRS) ? (o_r_data | i_w_data) : i_w_data;

// ------------------------------
// CSR state update
// ------------------------------
always_ff @(posedge clk) begin
    if (i_rst) begin
        csr_mscratch <= '0;
        csr_mepc     <= '0;
        csr_mcause   <= '0;
        csr_mtvec    <= MTVEC_INIT;
    end else if (i_take_exc) begin
        csr_mepc   <= i_exc_pc;             // Trapping instruction
        csr_mcause <= i_exc_cause;
    end else if (w_en) begin
        case (i_addr)
            CSR_MSCRATCH: csr_mscratch <= w_value;
            CSR_MEPC:     csr_mepc     <= {w_value[XLEN-1:2], 2'b00};
            CSR_MCAUSE:   csr_mcause   <= w_value;
            CSR_MTVEC:    csr_mtvec    <= {w_value[XLEN-1:2], 2'b00};   // Direct mode only
            default:      ;
        endcase
    end
end

assign o_new_pc = i_mret ? csr_mepc : csr_mtvec;

endmodule : pipe_csr

/* logic/pipe_mprf.sv */
/*
 * Integer register file, two asynchronous read ports, one write port
 */

`timescale 1ns/1ps

module pipe_mprf import core_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [REG_ADDR_W-1:0] i_rs2_addr,
    input  logic                  i_w_req,
    input  logic [REG_ADDR_W-1:0] i_rd_addr,
    input  logic [XLEN-1:0]       i_rd_data,
    output logic [XLEN-1:0]       o_rs1_data,
    output logic [XLEN-1:0]       o_rs2_data
);

logic [XLEN-1:0] regs [1:31];   // x0 has no storage

assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

always_ff @(posedge clk) begin
    if (i_w_req && i_rd_addr != '0) begin
        regs[i_rd_addr] <= i_rd_data;
    end
end

endmodule : pipe_mprf

/* logic/pipe_idu.sv */
/*
 * Instruction decoder: operation, register fields, I-immediate, CSR field
 */

`timescale 1ns/1ps

module pipe_idu import core_pkg::*; (
    input  logic [XLEN-1:0]       i_instr,
    output alu_op_e               o_op,
    output logic [REG_ADDR_W-1:0] o_rs1_addr,
    output logic [REG_ADDR_W-1:0] o_rs2_addr,
    output logic [REG_ADDR_W-1:0] o_rd_addr,
    output logic [XLEN-1:0]       o_imm,
    output logic                  o_use_imm,
    output logic [CSR_ADDR_W-1:0] o_csr_addr
);

localparam logic [6:0]      OPC_OP     = 7'b0110011;
localparam logic [6:0]      OPC_OP_IMM = 7'b0010011;
localparam logic [6:0]      OPC_SYSTEM = 7'b1110011;
localparam logic [XLEN-1:0] INSTR_ECALL = 32'h0000_0073;
localparam logic [XLEN-1:0] INSTR_MRET  = 32'h3020_0073;

logic [6:0] opcode;
logic [2:0] funct3;
logic [6:0] funct7;

assign opcode = i_instr[6:0];
assign funct3 = i_instr[14:12];
assign funct7 = i_instr[31:25];

assign o_rd_addr  = i_instr[11:7];
assign o_rs1_addr = i_instr[19:15];
assign o_rs2_addr = i_instr[24:20];
assign o_csr_addr = i_instr[31:20];
assign o_imm      = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};   // Sign-extended I-imm

always_comb begin
    o_op      = OP_ILLEGAL;         // Anything unlisted stays illegal
    o_use_imm = 1'b0;
    case (opcode)
        OPC_OP: begin
            if (funct7 == 7'b0000000) begin
                case (funct3)
                    3'b000:  o_op = OP_ADD;
                    3'b100:  o_op = OP_XOR;
                    3'b110:  o_op = OP_OR;
                    3'b111:  o_op = OP_AND;
                    default: o_op = OP_ILLEGAL;
                endcase
            end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                o_op = OP_SUB;
            end
        end
        OPC_OP_IMM: begin
            if (funct3 == 3'b000) begin
                o_op      = OP_ADD;         // ADDI
                o_use_imm = 1'b1;
            end
        end
        OPC_SYSTEM: begin
            case (funct3)
                3'b001:  o_op = OP_CSRRW;
                3'b010:  o_op = OP_CSRRS;
                3'b000: begin
                    if (i_instr == INSTR_ECALL) begin
                        o_op = OP_ECALL;
                    end else if (i_instr == INSTR_MRET) begin
                        o_op = OP_MRET;
                    end
                end
                default: o_op = OP_ILLEGAL;
            endcase
        end
        default: o_op = OP_ILLEGAL;
    endcase
end

endmodule : pipe_idu

/* logic/pipe_ifu.sv */
/*
 * Instruction fetch unit: fetch PC, request level toward the instruction
 * memory and the one-entry fetched-instruction buffer
 */

`timescale 1ns/1ps

module pipe_ifu import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            i_rst,
    input  logic            i_imem_ack,
    input  logic [XLEN-1:0] i_imem_rdata,
    input  logic            i_new_pc_req,
    input  logic [XLEN-1:0] i_new_pc,
    output logic            o_imem_req,
    output logic [XLEN-1:0] o_imem_addr,
    output logic [XLEN-1:0] o_instr,
    output logic [XLEN-1:0] o_instr_pc,
    output logic            o_instr_vd
);

logic [XLEN-1:0] fetch_pc;      // Address of the pending request
logic            req_r;
logic            fetch_done;    // Word accepted this cycle
logic [XLEN-1:0] buf_instr;
logic [XLEN-1:0] buf_pc;
logic            buf_vd;

// A redirect replaces the pending address in the same cycle
assign o_imem_addr = i_new_pc_req ? i_new_pc : fetch_pc;
assign o_imem_req  = req_r;
assign fetch_done  = req_r & i_imem_ack;

// ------------------------------
// Request and PC control
// ------------------------------
always_ff @(posedge clk) begin
    if (i_rst) begin
        req_r    <= 1'b0;
        fetch_pc <= RESET_PC;
        buf_vd   <= 1'b0;
    end else begin
        req_r  <= 1'b1;                         // Fetch runs continuously
        buf_vd <= fetch_done;                   // Valid for one cycle
        if (fetch_done) begin
            fetch_pc <= o_imem_addr + XLEN'(4);
        end else if (i_new_pc_req) begin
            fetch_pc <= i_new_pc;               // Hold target until ack
        end
    end
end

// Fetched word and the address it belongs to
always_ff @(posedge clk) begin
    if (fetch_done) begin
        buf_instr <= i_imem_rdata;
        buf_pc    <= o_imem_addr;
    end
end

assign o_instr    = buf_instr;
assign o_instr_pc = buf_pc;
assign o_instr_vd = buf_vd;

endmodule : pipe_ifu

/* logic/core_pkg.sv */
/*
 * Core-wide widths, decoded operation and CSR address encodings,
 * machine trap cause codes
 */

package core_pkg;

    parameter int XLEN       = 32;  // Data and address width
    parameter int REG_ADDR_W = 5;   // Register file address width
    parameter int CSR_ADDR_W = 12;  // CSR address width

    // Decoded operation
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_CSRRW,
        OP_CSRRS,
        OP_ECALL,
        OP_MRET,
        OP_ILLEGAL
    } alu_op_e;

    // Supported machine CSRs
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MHARTID  = 12'hF14
    } csr_addr_e;

    parameter logic [XLEN-1:0] CAUSE_ILLEGAL = 32'd2;   // Illegal instruction
    parameter logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;  // ECALL from M-mode

endpackage : core_pkg
